// ==== Bender.yml ====
package:
  name: dcache

sources:
  - files:
      - source/dcache_pkg.sv
      - source/dcache_tags.sv
      - source/dcache_data.sv
      - source/dcache_ctrl.sv
      - source/dcache_top.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/tb_mem.sv
      - test/tb_dcache.sv

// ==== files.f ====
source/dcache_pkg.sv
source/dcache_tags.sv
source/dcache_data.sv
source/dcache_ctrl.sv
source/dcache_top.sv
test/tb_clock.sv
test/tb_mem.sv
test/tb_dcache.sv

// ==== source/dcache_ctrl.sv ====
// data cache controller for miss fill, dirty writeback, halt flush and the ll/sc link
`timescale 1ns/1ps

module dcache_ctrl #(
	parameter int SETS = dcache_pkg::NUM_SETS
) (
	input  logic              CLK,
	input  logic              nRST,
	input  logic              dmem_ren_i,
	input  logic              dmem_wen_i,
	input  logic              datomic_i,
	input  dcache_pkg::word_t dmem_addr_i,
	input  dcache_pkg::word_t dmem_store_i,
	input  logic              halt_i,
	output logic              dhit_o,
	output dcache_pkg::word_t dmem_load_o,
	output logic              flushed_o,
	output logic              mem_ren_o,
	output logic              mem_wen_o,
	output dcache_pkg::word_t mem_addr_o,
	output dcache_pkg::word_t mem_store_o,
	input  dcache_pkg::word_t mem_load_i,
	input  logic              mem_wait_i,
	output dcache_pkg::idx_t  lookup_idx_o,
	output dcache_pkg::tag_t  lookup_tag_o,
	output logic              fill_o,
	output logic              fill_way_o,
	output dcache_pkg::tag_t  fill_tag_o,
	output logic              set_dirty_o,
	output logic              clean_o,
	output logic              clean_way_o,
	output logic              touch_o,
	output logic              touch_way_o,
	input  logic              hit_i,
	input  logic              hit_way_i,
	input  logic              victim_way_i,
	input  logic              victim_dirty_i,
	input  dcache_pkg::tag_t  victim_tag_i,
	input  logic              any_dirty_i,
	input  logic              dirty_way_i,
	input  dcache_pkg::tag_t  dirty_tag_i,
	output logic              data_way_o,
	output logic              data_wr_en_o,
	output logic              data_wr_word_o,
	output dcache_pkg::word_t data_wr_data_o,
	input  dcache_pkg::word_t word0_i,
	input  dcache_pkg::word_t word1_i
);
	import dcache_pkg::*;

	localparam int CNT_W = $clog2(SETS) + 1;

	dstate_t          state, next_state;
	logic [CNT_W-1:0] flush_cnt, next_flush_cnt;
	dcachef_t         req;
	logic             req_v, ll, sc, sc_ok, wr_hit;
	logic             word_done, flushing, fill_sel;
	logic             link_valid;
	logic [29:0]      link_addr;   // word address

	assign req       = dcachef_t'(dmem_addr_i);
	assign req_v     = dmem_ren_i | dmem_wen_i;
	assign ll        = datomic_i & dmem_ren_i;
	assign sc        = datomic_i & dmem_wen_i;
	assign sc_ok     = link_valid && (link_addr == dmem_addr_i[31:2]);
	assign word_done = !mem_wait_i;
	assign flushing  = (state == CLEAN) || (state == FLUSH1) || (state == FLUSH2) ||
		(state == HALTED);

	// cpu side
	assign dhit_o      = (state == IDLE) && req_v && hit_i;
	assign wr_hit      = dhit_o && dmem_wen_i && (!sc || sc_ok);   // failed sc writes nothing
	assign dmem_load_o = sc ? {31'b0, sc_ok} : (req.blkoff ? word1_i : word0_i);
	assign flushed_o   = (state == HALTED);

	always_comb
	begin
		next_state     = state;
		next_flush_cnt = flush_cnt;
		case (state)
			IDLE:
				if (halt_i)
					next_state = CLEAN;
				else if (req_v && !hit_i)
					next_state = victim_dirty_i ? WB1 : LD1;
			WB1:
				if (word_done)
					next_state = WB2;
			WB2:
				if (word_done)
					next_state = LD1;
			LD1:
				if (word_done)
					next_state = LD2;
			LD2:
				if (word_done)
					next_state = IDLE;
			CLEAN:
				if (flush_cnt == SETS)
					next_state = HALTED;
				else if (any_dirty_i)
					next_state = FLUSH1;
				else
					next_flush_cnt = flush_cnt + 1'b1;
			FLUSH1:
				if (word_done)
					next_state = FLUSH2;
			FLUSH2:
				if (word_done)
					next_state = CLEAN;   // rescan, other way may be dirty too
			HALTED:
				next_state = HALTED;
			default:
				next_state = IDLE;
		endcase
	end

	// memory side
	assign mem_ren_o = (state == LD1) || (state == LD2);
	assign mem_wen_o = (state == WB1) || (state == WB2) || (state == FLUSH1) ||
		(state == FLUSH2);

	always_comb
	begin
		mem_addr_o  = '0;
		mem_store_o = '0;
		case (state)
			WB1, WB2:
			begin
				mem_addr_o  = blk_addr(victim_tag_i, req.idx, state == WB2);
				mem_store_o = (state == WB2) ? word1_i : word0_i;
			end
			LD1, LD2:
				mem_addr_o = blk_addr(req.tag, req.idx, state == LD2);
			FLUSH1, FLUSH2:
			begin
				mem_addr_o  = blk_addr(dirty_tag_i, lookup_idx_o, state == FLUSH2);
				mem_store_o = (state == FLUSH2) ? word1_i : word0_i;
			end
			default:
				mem_addr_o = '0;
		endcase
	end

	// tag array
	assign lookup_idx_o = flushing ? idx_t'(flush_cnt) : req.idx;
	assign lookup_tag_o = req.tag;
	assign touch_o      = dhit_o;
	assign touch_way_o  = hit_way_i;
	assign set_dirty_o  = wr_hit;
	assign fill_o       = (state == LD2) && word_done;
	assign fill_way_o   = victim_way_i;
	assign fill_tag_o   = req.tag;
	assign clean_o      = ((state == WB2) || (state == FLUSH2)) && word_done;
	assign clean_way_o  = (state == WB2) ? victim_way_i : dirty_way_i;

	// data array
	assign fill_sel       = mem_ren_o;
	assign data_way_o     = (state == IDLE) ? hit_way_i : (flushing ? dirty_way_i : victim_way_i);
	assign data_wr_en_o   = wr_hit || (fill_sel && word_done);
	assign data_wr_word_o = fill_sel ? (state == LD2) : req.blkoff;
	assign data_wr_data_o = fill_sel ? mem_load_i : dmem_store_i;

	always_ff @(posedge CLK, negedge nRST)
	begin
		if (!nRST)
		begin
			state      <= IDLE;
			flush_cnt  <= '0;
			link_valid <= 1'b0;
		end
		else
		begin
			state     <= next_state;
			flush_cnt <= next_flush_cnt;
			if (ll && dhit_o)
				link_valid <= 1'b1;
			else if (wr_hit && (link_addr == dmem_addr_i[31:2]))
				link_valid <= 1'b0;   // any store to the linked word breaks the link
		end
	end

	always_ff @(posedge CLK)
	begin
		if (ll && dhit_o)
			link_addr <= dmem_addr_i[31:2];
	end

	a_one_strobe: assert property (@(posedge CLK) disable iff (!nRST)
		!(mem_ren_o && mem_wen_o))
		else $error("memory read and write strobes high together");

	// once flushed, the tag array must report the set under lookup clean
	a_flushed_clean: assert property (@(posedge CLK) disable iff (!nRST)
		flushed_o |-> !any_dirty_i)
		else $error("flushed_o raised with a dirty line left");

	// the writeback must have cleaned the victim before its block is refilled
	a_fill_clean: assert property (@(posedge CLK) disable iff (!nRST)
		(state == LD1) |-> !victim_dirty_i)
		else $error("fill started over a dirty victim");

endmodule

// ==== source/dcache_data.sv ====
// two-way word storage of the data cache with single-word writes and block reads
`timescale 1ns/1ps

module dcache_data #(
	parameter int SETS = dcache_pkg::NUM_SETS
) (
	input  logic              CLK,
	input  logic              nRST,
	input  dcache_pkg::idx_t  idx_i,
	input  logic              way_i,
	input  logic              wr_en_i,
	input  logic              wr_word_i,
	input  dcache_pkg::word_t wr_data_i,
	output dcache_pkg::word_t word0_o,
	output dcache_pkg::word_t word1_o
);
	import dcache_pkg::*;

	word_t mem_q [SETS][2][BLK_WORDS];

	always_ff @(posedge CLK)
	begin
		if (wr_en_i && nRST)   // no writes while held in reset
			mem_q[idx_i][way_i][wr_word_i] <= wr_data_i;
	end

	// whole block of the selected way
	assign word0_o = mem_q[idx_i][way_i][0];
	assign word1_o = mem_q[idx_i][way_i][1];

endmodule

// ==== source/dcache_pkg.sv ====
// shared address fields, geometry and controller states of the data cache
package dcache_pkg;

	typedef logic [31:0] word_t;
	typedef logic [25:0] tag_t;     // addr[31:6]
	typedef logic [2:0]  idx_t;     // addr[5:3]

	localparam int NUM_SETS  = 8;
	localparam int BLK_WORDS = 2;

	typedef struct packed {
		tag_t       tag;
		idx_t       idx;
		logic       blkoff;
		logic [1:0] bytoff;    // ignored, word accesses only
	} dcachef_t;

	typedef enum logic [3:0] {
		IDLE   = 4'd0,
		WB1    = 4'd1,
		WB2    = 4'd2,
		LD1    = 4'd3,
		LD2    = 4'd4,
		CLEAN  = 4'd5,
		FLUSH1 = 4'd6,
		FLUSH2 = 4'd7,
		HALTED = 4'd8
	} dstate_t;

	// word address inside a block
	function automatic word_t blk_addr(tag_t tag, idx_t idx, logic blkoff);
		return {tag, idx, blkoff, 2'b00};
	endfunction

endpackage

// ==== source/dcache_tags.sv ====
// tag store of the data cache with valid, dirty and lru state and the hit and victim lookup
`timescale 1ns/1ps

module dcache_tags #(
	parameter int SETS = dcache_pkg::NUM_SETS
) (
	input  logic             CLK,
	input  logic             nRST,
	input  dcache_pkg::idx_t lookup_idx_i,
	input  dcache_pkg::tag_t lookup_tag_i,
	input  logic             fill_i,
	input  logic             fill_way_i,
	input  dcache_pkg::tag_t fill_tag_i,
	input  logic             set_dirty_i,
	input  logic             clean_i,
	input  logic             clean_way_i,
	input  logic             touch_i,
	input  logic             touch_way_i,
	output logic             hit_o,
	output logic             hit_way_o,
	output logic             victim_way_o,
	output logic             victim_dirty_o,
	output dcache_pkg::tag_t victim_tag_o,
	output logic             any_dirty_o,
	output logic             dirty_way_o,
	output dcache_pkg::tag_t dirty_tag_o
);
	import dcache_pkg::*;

	logic [SETS-1:0] valid_q [2];
	logic [SETS-1:0] dirty_q [2];
	logic [SETS-1:0] lru_q;           // way to evict next
	tag_t            tag_q   [2][SETS];
	logic [1:0]      match;

	always_comb
	begin
		for (int w = 0; w < 2; w++)
			match[w] = valid_q[w][lookup_idx_i] && (tag_q[w][lookup_idx_i] == lookup_tag_i);
	end

	assign hit_o          = |match;
	assign hit_way_o      = match[1];
	assign victim_way_o   = lru_q[lookup_idx_i];
	assign victim_dirty_o = dirty_q[victim_way_o][lookup_idx_i];
	assign victim_tag_o   = tag_q[victim_way_o][lookup_idx_i];

	// flush scan view of the set
	assign any_dirty_o = dirty_q[0][lookup_idx_i] | dirty_q[1][lookup_idx_i];
	assign dirty_way_o = !dirty_q[0][lookup_idx_i];   // way 0 goes first
	assign dirty_tag_o = tag_q[dirty_way_o][lookup_idx_i];

	always_ff @(posedge CLK, negedge nRST)
	begin
		if (!nRST)
		begin
			for (int w = 0; w < 2; w++)
			begin
				valid_q[w] <= '0;
				dirty_q[w] <= '0;
			end
			lru_q <= '0;
		end
		else
		begin
			if (fill_i)
			begin
				valid_q[fill_way_i][lookup_idx_i] <= 1'b1;
				dirty_q[fill_way_i][lookup_idx_i] <= 1'b0;
			end
			if (clean_i)
				dirty_q[clean_way_i][lookup_idx_i] <= 1'b0;
			if (set_dirty_i && hit_o)
				dirty_q[hit_way_o][lookup_idx_i] <= 1'b1;
			if (touch_i)
				lru_q[lookup_idx_i] <= !touch_way_i;   // other way becomes lru
		end
	end

	always_ff @(posedge CLK)
	begin
		if (fill_i)
			tag_q[fill_way_i][lookup_idx_i] <= fill_tag_i;
	end

endmodule

// ==== source/dcache_top.sv ====
// two-way write-back data cache with the controller, tag array and data array
`timescale 1ns/1ps

module dcache_top #(
	parameter int SETS = dcache_pkg::NUM_SETS
) (
	input  logic              CLK,
	input  logic              nRST,
	input  logic              dmem_ren_i,
	input  logic              dmem_wen_i,
	input  logic              datomic_i,
	input  dcache_pkg::word_t dmem_addr_i,
	input  dcache_pkg::word_t dmem_store_i,
	input  logic              halt_i,
	output logic              dhit_o,
	output dcache_pkg::word_t dmem_load_o,
	output logic              flushed_o,
	output logic              mem_ren_o,
	output logic              mem_wen_o,
	output dcache_pkg::word_t mem_addr_o,
	output dcache_pkg::word_t mem_store_o,
	input  dcache_pkg::word_t mem_load_i,
	input  logic              mem_wait_i
);
	import dcache_pkg::*;

	idx_t  lookup_idx;
	tag_t  lookup_tag, fill_tag, victim_tag, dirty_tag;
	logic  fill, fill_way, set_dirty, clean, clean_way, touch, touch_way;
	logic  hit, hit_way, victim_way, victim_dirty, any_dirty, dirty_way;
	logic  data_way, data_wr_en, data_wr_word;
	word_t data_wr_data, word0, word1;

	dcache_ctrl #(.SETS(SETS)) u_ctrl (
		.CLK            (CLK),
		.nRST           (nRST),
		.dmem_ren_i     (dmem_ren_i),
		.dmem_wen_i     (dmem_wen_i),
		.datomic_i      (datomic_i),
		.dmem_addr_i    (dmem_addr_i),
		.dmem_store_i   (dmem_store_i),
		.halt_i         (halt_i),
		.dhit_o         (dhit_o),
		.dmem_load_o    (dmem_load_o),
		.flushed_o      (flushed_o),
		.mem_ren_o      (mem_ren_o),
		.mem_wen_o      (mem_wen_o),
		.mem_addr_o     (mem_addr_o),
		.mem_store_o    (mem_store_o),
		.mem_load_i     (mem_load_i),
		.mem_wait_i     (mem_wait_i),
		.lookup_idx_o   (lookup_idx),
		.lookup_tag_o   (lookup_tag),
		.fill_o         (fill),
		.fill_way_o     (fill_way),
		.fill_tag_o     (fill_tag),
		.set_dirty_o    (set_dirty),
		.clean_o        (clean),
		.clean_way_o    (clean_way),
		.touch_o        (touch),
		.touch_way_o    (touch_way),
		.hit_i          (hit),
		.hit_way_i      (hit_way),
		.victim_way_i   (victim_way),
		.victim_dirty_i (victim_dirty),
		.victim_tag_i   (victim_tag),
		.any_dirty_i    (any_dirty),
		.dirty_way_i    (dirty_way),
		.dirty_tag_i    (dirty_tag),
		.data_way_o     (data_way),
		.data_wr_en_o   (data_wr_en),
		.data_wr_word_o (data_wr_word),
		.data_wr_data_o (data_wr_data),
		.word0_i        (word0),
		.word1_i        (word1)
	);

	dcache_tags #(.SETS(SETS)) u_tags (
		.CLK            (CLK),
		.nRST           (nRST),
		.lookup_idx_i   (lookup_idx),
		.lookup_tag_i   (lookup_tag),
		.fill_i         (fill),
		.fill_way_i     (fill_way),
		.fill_tag_i     (fill_tag),
		.set_dirty_i    (set_dirty),
		.clean_i        (clean),
		.clean_way_i    (clean_way),
		.touch_i        (touch),
		.touch_way_i    (touch_way),
		.hit_o          (hit),
		.hit_way_o      (hit_way),
		.victim_way_o   (victim_way),
		.victim_dirty_o (victim_dirty),
		.victim_tag_o   (victim_tag),
		.any_dirty_o    (any_dirty),
		.dirty_way_o    (dirty_way),
		.dirty_tag_o    (dirty_tag)
	);

	// same set index as the tag lookup
	dcache_data #(.SETS(SETS)) u_data (
		.CLK       (CLK),
		.nRST      (nRST),
		.idx_i     (lookup_idx),
		.way_i     (data_way),
		.wr_en_i   (data_wr_en),
		.wr_word_i (data_wr_word),
		.wr_data_i (data_wr_data),
		.word0_o   (word0),
		.word1_o   (word1)
	);

endmodule

// ==== test/tb_clock.sv ====
// clock and reset source of the data cache testbench
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD_NS  = 20,
	parameter int RST_CYCLES = 16
) (
	output logic CLK,
	output logic nRST
);

	initial
	begin
		CLK = 1'b0;
		forever
			#(PERIOD_NS / 2) CLK = ~CLK;
	end

	initial
	begin
		nRST = 1'b0;
		repeat (RST_CYCLES) @(posedge CLK);
		@(negedge CLK);
		nRST = 1'b1;   // released mid-cycle
	end

endmodule

// ==== test/tb_dcache.sv ====
// testbench of the data cache against a shadow memory reference
`timescale 1ns/1ps

module tb_dcache;
	import dcache_pkg::*;

	localparam int MEM_WORDS      = 1024;
	localparam int AW             = $clog2(MEM_WORDS);
	localparam int ACCESS_TIMEOUT = 100;
	localparam int FLUSH_TIMEOUT  = 2000;
	localparam int K_LD           = 0;
	localparam int K_ST           = 1;
	localparam int K_LL           = 2;
	localparam int K_SC           = 3;

	logic   CLK, nRST;
	logic   dmem_ren_i, dmem_wen_i, datomic_i, halt_i;
	word_t  dmem_addr_i, dmem_store_i, dmem_load_o;
	logic   dhit_o, flushed_o;
	logic   mem_ren_o, mem_wen_o, mem_wait_i;
	word_t  mem_addr_o, mem_store_o, mem_load_i;

	word_t  shadow [MEM_WORDS];
	logic   link_ok;
	int     link_word;
	int     req_kind;
	word_t  req_addr, req_data, hit_expect;
	word_t  wr_log [$];   // completed memory writes
	integer seed;
	word_t  load, rnd_addr, rnd_data;
	int     cycles, wait_n;

	tb_clock #(.PERIOD_NS(20), .RST_CYCLES(16)) u_clk (
		.CLK  (CLK),
		.nRST (nRST)
	);

	tb_mem #(.DEPTH(MEM_WORDS)) u_mem (
		.CLK         (CLK),
		.nRST        (nRST),
		.mem_ren_i   (mem_ren_o),
		.mem_wen_i   (mem_wen_o),
		.mem_addr_i  (mem_addr_o),
		.mem_store_i (mem_store_o),
		.mem_load_o  (mem_load_i),
		.mem_wait_o  (mem_wait_i)
	);

	dcache_top #(.SETS(NUM_SETS)) u_dut (
		.CLK          (CLK),
		.nRST         (nRST),
		.dmem_ren_i   (dmem_ren_i),
		.dmem_wen_i   (dmem_wen_i),
		.datomic_i    (datomic_i),
		.dmem_addr_i  (dmem_addr_i),
		.dmem_store_i (dmem_store_i),
		.halt_i       (halt_i),
		.dhit_o       (dhit_o),
		.dmem_load_o  (dmem_load_o),
		.flushed_o    (flushed_o),
		.mem_ren_o    (mem_ren_o),
		.mem_wen_o    (mem_wen_o),
		.mem_addr_o   (mem_addr_o),
		.mem_store_o  (mem_store_o),
		.mem_load_i   (mem_load_i),
		.mem_wait_i   (mem_wait_i)
	);

	function automatic int word_index(input word_t addr);
		return int'(addr[AW+1:2]);
	endfunction

	// applies one completed access to the shadow memory and link model
	function automatic word_t expected_load(input int kind, input word_t addr, input word_t data);
		int    w;
		word_t result;
		w      = word_index(addr);
		result = shadow[w];
		case (kind)
			K_LL:
			begin
				link_ok   = 1'b1;
				link_word = w;
			end
			K_ST:
			begin
				shadow[w] = data;
				if (link_word == w)
					link_ok = 1'b0;
			end
			K_SC:
				if (link_ok && link_word == w)
				begin
					shadow[w] = data;
					link_ok   = 1'b0;
					result    = 32'd1;
				end
				else
					result = 32'd0;
			default:
				result = shadow[w];
		endcase
		return result;
	endfunction

	task automatic stop_on_error();
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic compare_word(input string name, input word_t expected, input word_t actual);
		if (actual !== expected)
		begin
			$display("mismatch %s expected %h actual %h", name, expected, actual);
			stop_on_error();
		end
	endtask

	task automatic wait_reset_release();
		int n;
		n = 0;
		@(posedge CLK);
		while (!nRST)
		begin
			if (n > 40)
			begin
				$display("reset was never released");
				stop_on_error();
			end
			else
			begin
				n++;
				@(posedge CLK);
			end
		end
	endtask

	// one cpu request, held until dhit_o
	task automatic cpu_access(input int kind, input word_t addr, input word_t data,
		output word_t result, output int latency);
		int n;
		@(negedge CLK);
		req_kind     = kind;
		req_addr     = addr;
		req_data     = data;
		dmem_ren_i   = (kind == K_LD) || (kind == K_LL);
		dmem_wen_i   = (kind == K_ST) || (kind == K_SC);
		datomic_i    = (kind == K_LL) || (kind == K_SC);
		dmem_addr_i  = addr;
		dmem_store_i = data;
		n = 0;
		@(posedge CLK);
		while (!dhit_o)
		begin
			if (n > ACCESS_TIMEOUT)
			begin
				$display("no dhit_o for the request to address %h", addr);
				stop_on_error();
			end
			else
			begin
				n++;
				@(posedge CLK);
			end
		end
		result  = dmem_load_o;
		latency = n;
		@(negedge CLK);
		dmem_ren_i = 1'b0;
		dmem_wen_i = 1'b0;
		datomic_i  = 1'b0;
	endtask

	always @(posedge CLK)
	begin
		if (nRST && dhit_o)
		begin
			hit_expect = expected_load(req_kind, req_addr, req_data);
			if (req_kind != K_ST)
				compare_word("dmem_load_o", hit_expect, dmem_load_o);
		end
	end

	// every written-back word must carry the latest stored value
	always @(posedge CLK)
	begin
		if (nRST && (mem_ren_o || mem_wen_o) && mem_addr_o >= MEM_WORDS * 4)
		begin
			$display("memory access outside the modelled range at %h", mem_addr_o);
			stop_on_error();
		end
		else if (nRST && mem_wen_o && !mem_wait_i)
		begin
			compare_word("mem_store_o", shadow[word_index(mem_addr_o)], mem_store_o);
			wr_log.push_back(mem_addr_o);
		end
	end

	initial
	begin
		seed         = 17800;
		dmem_ren_i   = 1'b0;
		dmem_wen_i   = 1'b0;
		datomic_i    = 1'b0;
		dmem_addr_i  = '0;
		dmem_store_i = '0;
		halt_i       = 1'b0;
		link_ok      = 1'b0;
		link_word    = -1;
		req_kind     = K_LD;
		req_addr     = '0;
		req_data     = '0;
		for (int i = 0; i < MEM_WORDS; i++)
			shadow[i] = i * 4;
		wait_reset_release();
		compare_word("dhit_o", 0, dhit_o);
		compare_word("flushed_o", 0, flushed_o);
		compare_word("mem_ren_o", 0, mem_ren_o);
		compare_word("mem_wen_o", 0, mem_wen_o);

		// read miss, then the other word of the block hits at once
		cpu_access(K_LD, 32'h100, 0, load, cycles);
		compare_word("dmem_load_o", 32'h100, load);
		if (cycles == 0)
		begin
			$display("load from an empty cache hit without a fill");
			stop_on_error();
		end
		cpu_access(K_LD, 32'h104, 0, load, cycles);
		compare_word("dmem_load_o", 32'h104, load);
		compare_word("hit latency", 0, cycles);

		// store and load back, neighbour untouched
		cpu_access(K_ST, 32'h100, 32'hcafe_0100, load, cycles);
		cpu_access(K_LD, 32'h100, 0, load, cycles);
		compare_word("dmem_load_o", 32'hcafe_0100, load);
		cpu_access(K_LD, 32'h104, 0, load, cycles);
		compare_word("dmem_load_o", 32'h104, load);

		// three tags in set 2
		cpu_access(K_ST, 32'h210, 32'h1111_0210, load, cycles);
		cpu_access(K_ST, 32'h250, 32'h2222_0250, load, cycles);
		wr_log.delete();
		cpu_access(K_ST, 32'h290, 32'h3333_0290, load, cycles);
		compare_word("writeback count", 2, wr_log.size());
		compare_word("writeback address", 32'h210, wr_log[0]);
		compare_word("writeback address", 32'h214, wr_log[1]);
		cpu_access(K_LD, 32'h210, 0, load, cycles);
		compare_word("dmem_load_o", 32'h1111_0210, load);

		// ll/sc pairs
		cpu_access(K_LL, 32'h318, 0, load, cycles);
		cpu_access(K_SC, 32'h318, 32'h4444_0318, load, cycles);
		compare_word("sc result", 1, load);
		cpu_access(K_LD, 32'h318, 0, load, cycles);
		compare_word("dmem_load_o", 32'h4444_0318, load);
		cpu_access(K_LL, 32'h318, 0, load, cycles);
		cpu_access(K_ST, 32'h318, 32'h5555_0318, load, cycles);
		cpu_access(K_SC, 32'h318, 32'h6666_0318, load, cycles);
		compare_word("sc result", 0, load);
		cpu_access(K_LD, 32'h318, 0, load, cycles);
		compare_word("dmem_load_o", 32'h5555_0318, load);

		for (int i = 0; i < 32; i++)
		begin
			rnd_addr = ($unsigned($random(seed)) % 256) * 4;
			rnd_data = $random(seed);
			cpu_access(K_ST, rnd_addr, rnd_data, load, cycles);
		end

		// halt and wait for the flush
		@(negedge CLK);
		halt_i = 1'b1;
		wait_n = 0;
		@(posedge CLK);
		while (!flushed_o)
		begin
			if (wait_n > FLUSH_TIMEOUT)
			begin
				$display("flushed_o did not rise after halt");
				stop_on_error();
			end
			else
			begin
				wait_n++;
				@(posedge CLK);
			end
		end
		for (int i = 0; i < MEM_WORDS; i++)
			compare_word($sformatf("mem[%0d]", i), shadow[i], u_mem.mem[i]);
		repeat (20)
		begin
			@(posedge CLK);
			compare_word("mem_ren_o", 0, mem_ren_o);
			compare_word("mem_wen_o", 0, mem_wen_o);
			compare_word("flushed_o", 1, flushed_o);
		end

		$display("All tests passed!");
		$finish;
	end

endmodule

// ==== test/tb_mem.sv ====
// word-addressed backing memory with a random wait of 0 to 3 cycles on every word
`timescale 1ns/1ps

module tb_mem #(
	parameter int DEPTH = 1024
) (
	input  logic        CLK,
	input  logic        nRST,
	input  logic        mem_ren_i,
	input  logic        mem_wen_i,
	input  logic [31:0] mem_addr_i,
	input  logic [31:0] mem_store_i,
	output logic [31:0] mem_load_o,
	output logic        mem_wait_o
);
	localparam int AW = $clog2(DEPTH);

	logic [31:0] mem [DEPTH];
	integer      seed;
	int          wait_left;
	logic        active;   // a word is in progress

	initial
	begin
		seed       = 17800;
		mem_wait_o = 1'b1;
		mem_load_o = '0;
		active     = 1'b0;
		wait_left  = 0;
		for (int i = 0; i < DEPTH; i++)
			mem[i] = i * 4;   // each word holds its own byte address
	end

	// outputs change on the falling edge only
	always @(negedge CLK or negedge nRST)
	begin
		if (!nRST)
		begin
			mem_wait_o = 1'b1;
			active     = 1'b0;
			wait_left  = 0;
		end
		else if (mem_ren_i || mem_wen_i)
		begin
			if (active && !mem_wait_o)
				active = 1'b0;   // last word finished on the rising edge
			if (!active)
			begin
				active    = 1'b1;
				wait_left = $unsigned($random(seed)) % 4;
			end
			else if (wait_left != 0)
				wait_left = wait_left - 1;
			mem_wait_o = (wait_left != 0);
			mem_load_o = mem[mem_addr_i[AW+1:2]];
			if (mem_wen_i && !mem_wait_o)
				mem[mem_addr_i[AW+1:2]] = mem_store_i;   // taken on the next rising edge
		end
		else
		begin
			active     = 1'b0;
			mem_wait_o = 1'b1;
		end
	end

endmodule
